//--- logic/lsu_pkg.sv
package lsu_pkg;

    // geometry of the cache
    localparam int ADDR_W     = 32;
    localparam int WAY_CNT    = 2;
    localparam int SET_CNT    = 256;
    localparam int INDEX_W    = 8;
    localparam int LINE_WORDS = 4;
    localparam int OFF_W      = 2;
    localparam int TAG_W      = 20;

    // victim lfsr must never start at zero
    localparam logic [7:0] LFSR_SEED = 8'hb5;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              write;
        mem_size_e         size;
        logic              is_signed;
        logic [31:0]       wdata;
    } lsu_req_t;

    // load data, zero for stores
    typedef struct packed {
        logic [31:0] data;
    } lsu_resp_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_t;

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [INDEX_W-1:0] index;
    } line_addr_t;

    typedef struct packed {
        logic       victim_dirty;
        line_addr_t victim_addr;
        line_addr_t fill_addr;
        logic       victim_way;
    } miss_cmd_t;

    typedef struct packed {
        logic             valid;
        logic [OFF_W-1:0] off;
        logic [31:0]      data;
    } fill_wr_t;

    typedef struct packed {
        logic             valid;
        logic [OFF_W-1:0] off;
    } wb_rd_t;

    typedef struct packed {
        logic              addr_valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic              wdata_valid;
        logic [31:0]       wdata;
        logic              wlast;
    } bus_req_t;

    typedef struct packed {
        logic        addr_ready;
        logic        rdata_valid;
        logic [31:0] rdata;
        logic        rlast;
        logic        wdata_ready;
    } bus_resp_t;

endpackage

//--- logic/sdp_ram.sv
`timescale 1ns/1ps

module sdp_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 256
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  entry_t                   wdata_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output entry_t                   rdata_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

    a_waddr_range: assert property (@(posedge clk) we_i |-> (waddr_i < DEPTH))
        else $error("sdp_ram write address out of range");

endmodule

//--- logic/data_align.sv
`timescale 1ns/1ps

module data_align import lsu_pkg::*; (
    input  mem_size_e   size_i,
    input  logic        is_signed_i,
    input  logic [1:0]  byte_off_i,
    input  logic [31:0] store_data_i,
    input  logic [31:0] word_i,
    output logic [3:0]  strobe_o,
    output logic [31:0] store_word_o,
    output logic [31:0] load_data_o
);

    logic [31:0] lane_word;
    logic        ext_bit;

    // store data moves up into its byte lanes
    assign store_word_o = store_data_i << {byte_off_i, 3'b000};

    // addressed bytes moved down to bit 0
    assign lane_word = word_i >> {byte_off_i, 3'b000};

    always_comb begin
        case (size_i)
            SIZE_BYTE: strobe_o = 4'b0001 << byte_off_i;
            SIZE_HALF: strobe_o = 4'b0011 << {byte_off_i[1], 1'b0};
            SIZE_WORD: strobe_o = 4'b1111;
            default:   strobe_o = 4'b0000;
        endcase
    end

    always_comb begin
        ext_bit     = 1'b0;
        load_data_o = word_i;
        case (size_i)
            SIZE_BYTE: begin
                ext_bit     = is_signed_i & lane_word[7];
                load_data_o = {{24{ext_bit}}, lane_word[7:0]};
            end
            SIZE_HALF: begin
                ext_bit     = is_signed_i & lane_word[15];
                load_data_o = {{16{ext_bit}}, lane_word[15:0]};
            end
            default: begin
                load_data_o = word_i;
            end
        endcase
    end

endmodule

//--- logic/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid_i,
    input  lsu_req_t    req_i,
    output logic        req_ready_o,
    output logic        resp_valid_o,
    output lsu_resp_t   resp_o,
    input  logic        resp_ready_i,
    output logic        miss_valid_o,
    output miss_cmd_t   miss_cmd_o,
    input  logic        miss_ready_i,
    input  logic        miss_done_i,
    input  wb_rd_t      wb_rd_i,
    output logic [31:0] wb_word_o,
    input  fill_wr_t    fill_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_RESP,
        S_MISS,
        S_WAIT,
        S_REPLAY
    } ctrl_state_e;

    ctrl_state_e state;
    ctrl_state_e state_next;
    lsu_req_t    req_q;
    lsu_resp_t   resp_q;
    miss_cmd_t   cmd_q;
    logic [7:0]  lfsr;

    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_idx;
    logic [OFF_W-1:0]   req_off;

    tag_t [WAY_CNT-1:0]       tag_rd;
    logic [WAY_CNT-1:0][31:0] data_rd;
    logic [WAY_CNT-1:0]       vld_rd;
    logic [WAY_CNT-1:0]       match;
    logic [WAY_CNT-1:0]       tag_we;
    logic [WAY_CNT-1:0]       data_we;
    logic                     hit;
    logic                     victim_way;
    logic [31:0]              hit_word;
    logic [31:0]              merged_word;

    logic [INDEX_W-1:0]       tag_raddr;
    logic [INDEX_W-1:0]       tag_waddr;
    logic [INDEX_W+OFF_W-1:0] data_raddr;
    logic [INDEX_W+OFF_W-1:0] data_waddr;
    tag_t                     tag_wdata;
    logic [31:0]              data_wdata;

    logic [3:0]  strobe;
    logic [31:0] store_word;
    logic [31:0] load_data;

    assign req_tag = req_q.addr[ADDR_W-1 -: TAG_W];
    assign req_idx = req_q.addr[OFF_W+2 +: INDEX_W];
    assign req_off = req_q.addr[2 +: OFF_W];

    for (genvar w = 0; w < WAY_CNT; w++) begin : g_way
        logic [SET_CNT-1:0] line_vld;
        logic               vld_q;

        sdp_ram #(.entry_t(tag_t), .DEPTH(SET_CNT)) u_tag_ram (
            .clk     (clk),
            .we_i    (tag_we[w]),
            .waddr_i (tag_waddr),
            .wdata_i (tag_wdata),
            .raddr_i (tag_raddr),
            .rdata_o (tag_rd[w])
        );

        sdp_ram #(.entry_t(logic [3:0][7:0]), .DEPTH(SET_CNT * LINE_WORDS)) u_data_ram (
            .clk     (clk),
            .we_i    (data_we[w]),
            .waddr_i (data_waddr),
            .wdata_i (data_wdata),
            .raddr_i (data_raddr),
            .rdata_o (data_rd[w])
        );

        // line valid flags per set, read in step with the tag ram
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                line_vld <= '0;
            end else if (tag_we[w]) begin
                line_vld[tag_waddr] <= 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            vld_q <= line_vld[tag_raddr];
        end

        assign vld_rd[w] = vld_q;
        assign match[w]  = vld_q && tag_rd[w].valid && (tag_rd[w].tag == req_tag);
    end

    assign hit        = |match;
    assign victim_way = lfsr[0];

    always_comb begin
        hit_word = data_rd[0];
        for (int w = 0; w < WAY_CNT; w++) begin
            if (match[w]) begin
                hit_word = data_rd[w];
            end
        end
    end

    data_align u_align (
        .size_i       (req_q.size),
        .is_signed_i  (req_q.is_signed),
        .byte_off_i   (req_q.addr[1:0]),
        .store_data_i (req_q.wdata),
        .word_i       (hit_word),
        .strobe_o     (strobe),
        .store_word_o (store_word),
        .load_data_o  (load_data)
    );

    // store bytes merged over the word read in the lookup
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged_word[8*b +: 8] = strobe[b] ? store_word[8*b +: 8] : hit_word[8*b +: 8];
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:   if (req_valid_i) state_next = S_LOOKUP;
            S_LOOKUP: state_next = hit ? S_RESP : S_MISS;
            S_RESP:   if (resp_ready_i) state_next = S_IDLE;
            S_MISS:   if (miss_ready_i) state_next = S_WAIT;
            S_WAIT:   if (miss_done_i) state_next = S_REPLAY;
            S_REPLAY: state_next = S_LOOKUP;
            default:  state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= S_IDLE;
            lfsr  <= LFSR_SEED;
        end else begin
            state <= state_next;
            // one lfsr step per miss
            if (state == S_LOOKUP && !hit) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;
        end
        if (state == S_LOOKUP && hit) begin
            resp_q.data <= req_q.write ? 32'd0 : load_data;
        end
        if (state == S_LOOKUP && !hit) begin
            cmd_q.victim_dirty <= vld_rd[victim_way] && tag_rd[victim_way].dirty;
            cmd_q.victim_addr  <= '{tag: tag_rd[victim_way].tag, index: req_idx};
            cmd_q.fill_addr    <= '{tag: req_tag, index: req_idx};
            cmd_q.victim_way   <= victim_way;
        end
    end

    // read port: new request, victim words, or the held request
    always_comb begin
        tag_raddr  = req_idx;
        data_raddr = {req_idx, req_off};
        if (state == S_IDLE) begin
            tag_raddr  = req_i.addr[OFF_W+2 +: INDEX_W];
            data_raddr = req_i.addr[2 +: INDEX_W+OFF_W];
        end else if (wb_rd_i.valid) begin
            data_raddr = {req_idx, wb_rd_i.off};
        end
    end

    // write port: refill beats, else store hits
    always_comb begin
        tag_we     = '0;
        data_we    = '0;
        tag_waddr  = req_idx;
        data_waddr = {req_idx, req_off};
        tag_wdata  = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
        data_wdata = merged_word;
        if (fill_i.valid) begin
            data_waddr                 = {req_idx, fill_i.off};
            data_wdata                 = fill_i.data;
            data_we[cmd_q.victim_way] = 1'b1;
            if (fill_i.off == OFF_W'(LINE_WORDS - 1)) begin
                tag_we[cmd_q.victim_way] = 1'b1;
                tag_wdata.dirty           = 1'b0;
            end
        end else if (state == S_LOOKUP && hit && req_q.write) begin
            data_we = match;
            tag_we  = match;
        end
    end

    assign wb_word_o    = data_rd[cmd_q.victim_way];
    assign req_ready_o  = (state == S_IDLE);
    assign resp_valid_o = (state == S_RESP);
    assign resp_o       = resp_q;
    assign miss_valid_o = (state == S_MISS);
    assign miss_cmd_o   = cmd_q;

    a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (resp_valid_o && !resp_ready_i) |=> (resp_valid_o && $stable(resp_o)))
        else $error("response changed while back-pressured");

endmodule

//--- logic/miss_engine.sv
`timescale 1ns/1ps

module miss_engine import lsu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        miss_valid_i,
    input  miss_cmd_t   miss_cmd_i,
    output logic        miss_ready_o,
    output logic        miss_done_o,
    output wb_rd_t      wb_rd_o,
    input  logic [31:0] wb_word_i,
    output fill_wr_t    fill_o,
    output bus_req_t    bus_req_o,
    input  bus_resp_t   bus_resp_i
);

    typedef enum logic [2:0] {
        ME_IDLE,
        ME_VREAD,
        ME_WADDR,
        ME_WDATA,
        ME_RADDR,
        ME_RDATA
    } me_state_e;

    me_state_e state;
    me_state_e state_next;
    miss_cmd_t cmd_q;

    // top bit of each counter marks done
    logic [OFF_W:0]   rd_cnt;
    logic [OFF_W:0]   wr_cnt;
    logic [OFF_W-1:0] fill_cnt;
    wb_rd_t           rd_dly;
    logic [31:0]      wb_buf [LINE_WORDS];
    logic             wlast;
    logic             wbeat;

    assign wlast = (wr_cnt[OFF_W-1:0] == OFF_W'(LINE_WORDS - 1));
    assign wbeat = bus_req_o.wdata_valid && bus_resp_i.wdata_ready;

    always_comb begin
        state_next = state;
        case (state)
            ME_IDLE: begin
                if (miss_valid_i) begin
                    state_next = miss_cmd_i.victim_dirty ? ME_VREAD : ME_RADDR;
                end
            end
            // last victim word lands in the done cycle
            ME_VREAD: if (rd_cnt[OFF_W]) state_next = ME_WADDR;
            ME_WADDR: if (bus_resp_i.addr_ready) state_next = ME_WDATA;
            ME_WDATA: if (wbeat && wlast) state_next = ME_RADDR;
            ME_RADDR: if (bus_resp_i.addr_ready) state_next = ME_RDATA;
            ME_RDATA: begin
                if (bus_resp_i.rdata_valid && bus_resp_i.rlast) begin
                    state_next = ME_IDLE;
                end
            end
            default: state_next = ME_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= ME_IDLE;
            rd_cnt      <= (OFF_W + 1)'(LINE_WORDS);
            wr_cnt      <= (OFF_W + 1)'(LINE_WORDS);
            fill_cnt    <= '0;
            rd_dly      <= '0;
            miss_done_o <= 1'b0;
        end else begin
            state <= state_next;
            if (state == ME_IDLE && miss_valid_i && miss_cmd_i.victim_dirty) begin
                rd_cnt <= '0;
            end else if (!rd_cnt[OFF_W]) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (state == ME_WADDR && bus_resp_i.addr_ready) begin
                wr_cnt <= '0;
            end else if (wbeat) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (state == ME_RADDR && bus_resp_i.addr_ready) begin
                fill_cnt <= '0;
            end else if (fill_o.valid) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            rd_dly      <= wb_rd_o;
            miss_done_o <= (state == ME_RDATA) && bus_resp_i.rdata_valid && bus_resp_i.rlast;
        end
    end

    always_ff @(posedge clk) begin
        if (miss_valid_i && miss_ready_o) begin
            cmd_q <= miss_cmd_i;
        end
        // victim words arrive one cycle after their read
        if (rd_dly.valid) begin
            wb_buf[rd_dly.off] <= wb_word_i;
        end
    end

    assign miss_ready_o  = (state == ME_IDLE);
    assign wb_rd_o.valid = (state == ME_VREAD) && !rd_cnt[OFF_W];
    assign wb_rd_o.off   = rd_cnt[OFF_W-1:0];

    assign fill_o.valid = (state == ME_RDATA) && bus_resp_i.rdata_valid;
    assign fill_o.off   = fill_cnt;
    assign fill_o.data  = bus_resp_i.rdata;

    always_comb begin
        bus_req_o       = '0;
        bus_req_o.wdata = wb_buf[wr_cnt[OFF_W-1:0]];
        case (state)
            ME_WADDR: begin
                bus_req_o.addr_valid = 1'b1;
                bus_req_o.write      = 1'b1;
                bus_req_o.addr       = {cmd_q.victim_addr, 4'b0000};
            end
            ME_WDATA: begin
                bus_req_o.wdata_valid = !wr_cnt[OFF_W];
                bus_req_o.wlast       = wlast;
            end
            ME_RADDR: begin
                bus_req_o.addr_valid = 1'b1;
                bus_req_o.addr       = {cmd_q.fill_addr, 4'b0000};
            end
            default: begin
                bus_req_o.addr_valid = 1'b0;
            end
        endcase
    end

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req_o.addr_valid && !bus_resp_i.addr_ready)
            |=> (bus_req_o.addr_valid && $stable(bus_req_o.addr)))
        else $error("bus address dropped or changed before address ready");

endmodule

//--- logic/lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid_i,
    input  lsu_req_t  req_i,
    output logic      req_ready_o,
    output logic      resp_valid_o,
    output lsu_resp_t resp_o,
    input  logic      resp_ready_i,
    output bus_req_t  bus_req_o,
    input  bus_resp_t bus_resp_i
);

    // controller to miss engine
    logic        miss_valid;
    miss_cmd_t   miss_cmd;
    logic        miss_ready;
    logic        miss_done;
    wb_rd_t      wb_rd;
    logic [31:0] wb_word;
    fill_wr_t    fill;

    lsu_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i),
        .miss_valid_o (miss_valid),
        .miss_cmd_o   (miss_cmd),
        .miss_ready_i (miss_ready),
        .miss_done_i  (miss_done),
        .wb_rd_i      (wb_rd),
        .wb_word_o    (wb_word),
        .fill_i       (fill)
    );

    miss_engine u_miss (
        .clk          (clk),
        .rst_n        (rst_n),
        .miss_valid_i (miss_valid),
        .miss_cmd_i   (miss_cmd),
        .miss_ready_o (miss_ready),
        .miss_done_o  (miss_done),
        .wb_rd_o      (wb_rd),
        .wb_word_i    (wb_word),
        .fill_o       (fill),
        .bus_req_o    (bus_req_o),
        .bus_resp_i   (bus_resp_i)
    );

endmodule

//--- tb/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

    localparam int DIRECTED_REQS = 39;
    localparam int RANDOM_REQS   = 300;
    localparam int RESET_CYCLES  = 16;
    // 400 cycles per request covers a dirty miss with heavy bus stalls
    localparam int MAX_CYCLES    = 400 * (DIRECTED_REQS + RANDOM_REQS) + RESET_CYCLES;
    localparam int MEM_WORDS     = 16384;

    logic      clk          = 1'b0;
    logic      rst_n        = 1'b0;
    logic      req_valid_i  = 1'b0;
    lsu_req_t  req_i        = '0;
    logic      req_ready_o;
    logic      resp_valid_o;
    lsu_resp_t resp_o;
    logic      resp_ready_i = 1'b1;
    bus_req_t  bus_req_o;
    bus_resp_t bus_resp_i   = '0;

    integer      seed         = 32'h55ac;
    logic [31:0] bus_rnd;
    logic        backpressure = 1'b0;
    int          cycle_cnt    = 0;
    int          value_errs   = 0;
    int          other_errs   = 0;
    int          req_cnt      = 0;
    int          resp_cnt     = 0;
    int          wb_lines     = 0;

    logic [31:0] bus_mem [MEM_WORDS];
    logic [31:0] shadow [MEM_WORDS];
    lsu_resp_t   exp_q [$];

    // open bursts seen on the bus
    logic        wr_open = 1'b0;
    logic        rd_open = 1'b0;
    logic [31:0] wr_base;
    logic [31:0] rd_base;
    int          wr_beat;
    int          rd_beat;
    bus_req_t    exp_beat;

    lsu_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_o       (resp_o),
        .resp_ready_i (resp_ready_i),
        .bus_req_o    (bus_req_o),
        .bus_resp_i   (bus_resp_i)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] fill_word(logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic int widx(logic [31:0] a);
        return int'(a[15:2]);
    endfunction

    // expected load value from the architectural word
    function automatic logic [31:0] expect_load(logic [31:0] word, mem_size_e size,
                                                logic [1:0] off, logic sgn);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (size)
            SIZE_BYTE: return sgn ? {{24{b[7]}}, b} : {24'd0, b};
            SIZE_HALF: return sgn ? {{16{h[15]}}, h} : {16'd0, h};
            default:   return word;
        endcase
    endfunction

    function automatic void apply_store(lsu_req_t r);
        int          i;
        logic [31:0] w;
        i = widx(r.addr);
        w = shadow[i];
        case (r.size)
            SIZE_BYTE: w[8*r.addr[1:0] +: 8] = r.wdata[7:0];
            SIZE_HALF: w[16*r.addr[1] +: 16] = r.wdata[15:0];
            default:   w = r.wdata;
        endcase
        shadow[i] = w;
    endfunction

    function automatic lsu_req_t make_req(logic [31:0] a, logic wr, mem_size_e s,
                                          logic sgn, logic [31:0] d);
        lsu_req_t r;
        r.addr      = a;
        r.write     = wr;
        r.size      = s;
        r.is_signed = sgn;
        r.wdata     = d;
        return r;
    endfunction

    task automatic check_resp(string name, lsu_resp_t exp, lsu_resp_t act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_bus(string name, bus_req_t exp, bus_req_t act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
            value_errs++;
        end
    endtask

    // expected value is fixed when the request is accepted
    task automatic issue(input lsu_req_t r);
        lsu_resp_t e;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= r;
        @(negedge clk);
        while (!req_ready_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
        e.data = r.write ? 32'd0 : expect_load(shadow[widx(r.addr)], r.size, r.addr[1:0],
                                               r.is_signed);
        if (r.write) begin
            apply_store(r);
        end
        exp_q.push_back(e);
        req_cnt++;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // bus slave with random stalls, plus response back-pressure
    always @(posedge clk) begin
        bus_rnd = $random(seed);
        if (!rst_n) begin
            bus_resp_i   <= '0;
            resp_ready_i <= 1'b1;
        end else begin
            bus_resp_i.addr_ready  <= bus_rnd[0] | bus_rnd[1];
            bus_resp_i.wdata_ready <= bus_rnd[2];
            if (rd_open && bus_rnd[3]) begin
                bus_resp_i.rdata_valid <= 1'b1;
                bus_resp_i.rdata       <= bus_mem[widx(rd_base) + rd_beat];
                bus_resp_i.rlast       <= (rd_beat == LINE_WORDS - 1);
            end else begin
                bus_resp_i.rdata_valid <= 1'b0;
                bus_resp_i.rlast       <= 1'b0;
            end
            resp_ready_i <= backpressure ? bus_rnd[4] : 1'b1;
        end
    end

    // transfers seen here complete at the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (bus_req_o.addr_valid && bus_resp_i.addr_ready) begin
                check_bit("bus_req_o.addr line aligned", 1'b1, bus_req_o.addr[3:0] == 4'd0);
                if (bus_req_o.write) begin
                    wr_open = 1'b1;
                    wr_base = bus_req_o.addr;
                    wr_beat = 0;
                end else begin
                    if (wr_open) begin
                        $display("t=%0t refill address issued before the writeback ended", $time);
                        other_errs++;
                    end
                    rd_open = 1'b1;
                    rd_base = bus_req_o.addr;
                    rd_beat = 0;
                end
            end
            if (bus_req_o.wdata_valid && bus_resp_i.wdata_ready) begin
                if (!wr_open) begin
                    $display("t=%0t write beat without a write address", $time);
                    other_errs++;
                end else begin
                    exp_beat       = bus_req_o;
                    exp_beat.wdata = shadow[widx(wr_base) + wr_beat];
                    exp_beat.wlast = (wr_beat == LINE_WORDS - 1);
                    check_bus("bus_req_o", exp_beat, bus_req_o);
                    bus_mem[widx(wr_base) + wr_beat] = bus_req_o.wdata;
                    wr_beat++;
                    if (wr_beat == LINE_WORDS) begin
                        wr_open = 1'b0;
                        wb_lines++;
                    end
                end
            end
            if (rd_open && bus_resp_i.rdata_valid) begin
                rd_beat++;
                if (bus_resp_i.rlast) begin
                    rd_open = 1'b0;
                end
            end
        end
    end

    // response compare against the queue of expected values
    always @(negedge clk) begin
        if (rst_n && resp_valid_o && resp_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("t=%0t response without an outstanding request", $time);
                other_errs++;
            end else begin
                check_resp("resp_o", exp_q.pop_front(), resp_o);
            end
            resp_cnt++;
        end
    end

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout after %0d cycles with %0d of %0d responses received",
                 cycle_cnt, resp_cnt, req_cnt);
        $display("test failed");
        $finish;
    end

    initial begin : main
        lsu_req_t    r;
        logic [31:0] bits;
        logic [31:0] addr;
        logic [1:0]  boff;
        mem_size_e   sz;

        for (int i = 0; i < MEM_WORDS; i++) begin
            bus_mem[i] = fill_word(32'(i) * 4);
            shadow[i]  = bus_mem[i];
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_bit("req_ready_o", 1'b1, req_ready_o);
        check_bit("resp_valid_o", 1'b0, resp_valid_o);
        check_bit("bus_req_o.addr_valid", 1'b0, bus_req_o.addr_valid);
        check_bit("bus_req_o.wdata_valid", 1'b0, bus_req_o.wdata_valid);

        // store then load, then a timed hit
        issue(make_req(32'h0000_0100, 1'b1, SIZE_WORD, 1'b0, 32'h1234_abcd));
        issue(make_req(32'h0000_0100, 1'b0, SIZE_WORD, 1'b0, 32'd0));
        wait_drain();
        issue(make_req(32'h0000_0100, 1'b0, SIZE_WORD, 1'b0, 32'd0));
        @(negedge clk);
        check_bit("resp_valid_o", 1'b0, resp_valid_o);
        @(negedge clk);
        check_bit("resp_valid_o", 1'b1, resp_valid_o);
        wait_drain();

        // sub-word stores merged into one word, then every load form
        issue(make_req(32'h0000_0200, 1'b1, SIZE_WORD, 1'b0, 32'h8f7e_6d5c));
        issue(make_req(32'h0000_0201, 1'b1, SIZE_BYTE, 1'b0, 32'h0000_0091));
        issue(make_req(32'h0000_0202, 1'b1, SIZE_HALF, 1'b0, 32'h0000_c3a5));
        for (int sg = 0; sg < 2; sg++) begin
            for (int off = 0; off < 4; off++) begin
                issue(make_req(32'h0000_0200 + off, 1'b0, SIZE_BYTE, sg[0], 32'd0));
            end
            issue(make_req(32'h0000_0200, 1'b0, SIZE_HALF, sg[0], 32'd0));
            issue(make_req(32'h0000_0202, 1'b0, SIZE_HALF, sg[0], 32'd0));
        end
        issue(make_req(32'h0000_0200, 1'b0, SIZE_WORD, 1'b0, 32'd0));

        // four dirty lines in one set, two ways
        for (int k = 0; k < 4; k++) begin
            issue(make_req(32'h0000_0440 + 32'h1000 * k + 4 * k, 1'b1, SIZE_WORD, 1'b0,
                           32'hc0de_0000 + k));
        end
        for (int k = 0; k < 4; k++) begin
            for (int w = 0; w < LINE_WORDS; w++) begin
                issue(make_req(32'h0000_0440 + 32'h1000 * k + 4 * w, 1'b0, SIZE_WORD, 1'b0,
                               32'd0));
            end
        end
        wait_drain();
        if (wb_lines < 2) begin
            $display("only %0d dirty lines were written back, at least 2 expected", wb_lines);
            other_errs++;
        end

        // random traffic over 4 tags x 4 sets
        backpressure <= 1'b1;
        for (int n = 0; n < RANDOM_REQS; n++) begin
            @(negedge clk);
            bits = $random(seed);
            sz   = (bits[1:0] == 2'd3) ? SIZE_WORD : mem_size_e'(bits[1:0]);
            case (sz)
                SIZE_BYTE: boff = bits[9:8];
                SIZE_HALF: boff = {bits[9], 1'b0};
                default:   boff = 2'd0;
            endcase
            addr = {18'd0, bits[3:2], 6'd0, bits[5:4], bits[7:6], boff};
            r    = make_req(addr, bits[10], sz, bits[11], $random(seed));
            issue(r);
        end
        wait_drain();
        backpressure <= 1'b0;

        repeat (4) @(negedge clk);
        check_bit("resp_valid_o", 1'b0, resp_valid_o);
        if (resp_cnt != req_cnt || exp_q.size() != 0) begin
            $display("%0d requests issued but %0d responses received", req_cnt, resp_cnt);
            other_errs++;
        end
        $display("errors: %0d value, %0d other (requests %0d, responses %0d, writebacks %0d)",
                 value_errs, other_errs, req_cnt, resp_cnt, wb_lines);
        if (value_errs + other_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
logic/lsu_pkg.sv
logic/sdp_ram.sv
logic/data_align.sv
logic/lsu_ctrl.sv
logic/miss_engine.sv
logic/lsu_top.sv
tb/tb_lsu.sv

//--- Makefile
# Verilator flow for the data cache testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

SRCS := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
